// ==== build.f ====
gmem_cfg_pkg.sv
gmem_axi_pkg.sv
gmem_aw_queue.sv
gmem_write_ctrl.sv
gmem_read_ctrl.sv
gmem_array.sv
global_mem.sv
tb_global_mem.sv

// ==== Bender.yml ====
package:
  name: global_mem

sources:
  - gmem_cfg_pkg.sv
  - gmem_axi_pkg.sv
  - gmem_aw_queue.sv
  - gmem_write_ctrl.sv
  - gmem_read_ctrl.sv
  - gmem_array.sv
  - global_mem.sv
  - target: simulation
    files:
      - tb_global_mem.sv

// ==== tb_global_mem.sv ====
`default_nettype none

module tb_global_mem;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_TESTS = 10;
   localparam int WAIT_MAX = 200;
   localparam int QUEUE_BURSTS = 9;

   typedef enum logic [1:0] {
      op_write,
      op_read,
      op_queue_fill
   } op_e;

   typedef struct packed {
      op_e         kind;
      logic [31:0] addr;
      logic [7:0]  len;
      logic [3:0]  id;
      logic [63:0] seed;
      logic [7:0]  strb;
      logic        throttle;
   } test_t;

   logic clk = 1'b0;
   logic nrst;

   gmem_axi_pkg::addr_req_t ar;
   gmem_axi_pkg::addr_req_t aw;
   gmem_axi_pkg::w_beat_t   w;
   gmem_axi_pkg::r_beat_t   r;
   gmem_axi_pkg::b_resp_t   b;

   logic arvalid;
   logic arready;
   logic awvalid;
   logic awready;
   logic wvalid;
   logic wready;
   logic rvalid;
   logic rready;
   logic bvalid;
   logic bready;

   test_t       tests [NUM_TESTS];
   string       names [NUM_TESTS];
   logic [63:0] ref_mem [1024];
   integer      seed = 91;
   int          errors;
   int          passed;
   int          failed;
   bit          timed_out;

   global_mem u_global_mem (
      .clk     (clk),
      .nrst    (nrst),
      .ar      (ar),
      .arvalid (arvalid),
      .arready (arready),
      .aw      (aw),
      .awvalid (awvalid),
      .awready (awready),
      .w       (w),
      .wvalid  (wvalid),
      .wready  (wready),
      .r       (r),
      .rvalid  (rvalid),
      .rready  (rready),
      .b       (b),
      .bvalid  (bvalid),
      .bready  (bready)
   );

   always #5 clk = ~clk;

   task automatic load_table();
      names[0] = "single_wr";
      tests[0] = '{op_write, 32'h1000_0040, 8'd0, 4'd3, 64'h0123_4567_89ab_cdef, 8'hff, 1'b0};
      names[1] = "single_rd";
      tests[1] = '{op_read, 32'h1000_0040, 8'd0, 4'd5, 64'h0, 8'h00, 1'b0};
      names[2] = "burst_fill";
      tests[2] = '{op_write, 32'h1000_0100, 8'd7, 4'd6, 64'hffee_ddcc_bbaa_9900, 8'hff, 1'b0};
      names[3] = "burst_merge";
      tests[3] = '{op_write, 32'h1000_0100, 8'd7, 4'd7, 64'h1111_2222_3333_4400, 8'h5a, 1'b0};
      names[4] = "burst_rd";
      tests[4] = '{op_read, 32'h1000_0100, 8'd7, 4'd8, 64'h0, 8'h00, 1'b0};
      names[5] = "throttled_rd";
      tests[5] = '{op_read, 32'h1000_0100, 8'd7, 4'd9, 64'h0, 8'h00, 1'b1};
      names[6] = "aw_queue";
      tests[6] = '{op_queue_fill, 32'h1000_0800, 8'd1, 4'd2, 64'h0a0b_0c0d_0000_0000, 8'hff, 1'b0};
      names[7] = "wrap_wr";
      tests[7] = '{op_write, 32'h1000_2018, 8'd0, 4'd1, 64'h5566_7788_99aa_bbcc, 8'hff, 1'b0};
      names[8] = "wrap_rd";
      tests[8] = '{op_read, 32'h1000_0018, 8'd0, 4'd4, 64'h0, 8'h00, 1'b0};
      names[9] = "queue_rd";
      tests[9] = '{op_read, 32'h1000_0800, 8'd15, 4'd11, 64'h0, 8'h00, 1'b1};
   endtask

   // reference decode removes the base and keeps the word index
   function automatic logic [9:0] ref_index(input logic [31:0] addr);
      logic [31:0] rel;
      rel = addr - 32'h1000_0000;
      return rel[12:3];
   endfunction

   // odd beats swap the strobe nibbles
   function automatic logic [7:0] beat_strb(input logic [7:0] strb, input int beat);
      return (beat % 2 == 1) ? {strb[3:0], strb[7:4]} : strb;
   endfunction

   task automatic do_aw(input gmem_axi_pkg::addr_req_t req);
      int cnt;
      cnt = 0;
      aw = req;
      awvalid = 1'b1;
      while (!awready && cnt < WAIT_MAX) begin
         @(negedge clk);
         cnt++;
      end
      if (!awready) begin
         $display("timeout: awready never rose for write id %0d", req.id);
         timed_out = 1'b1;
         errors++;
      end
      @(negedge clk);
      awvalid = 1'b0;
   endtask

   task automatic do_ar(input gmem_axi_pkg::addr_req_t req);
      int cnt;
      cnt = 0;
      ar = req;
      arvalid = 1'b1;
      while (!arready && cnt < WAIT_MAX) begin
         @(negedge clk);
         cnt++;
      end
      if (!arready) begin
         $display("timeout: arready never rose for read id %0d", req.id);
         timed_out = 1'b1;
         errors++;
      end
      @(negedge clk);
      arvalid = 1'b0;
   endtask

   task automatic send_burst(input logic [31:0] addr, input logic [7:0] len,
                             input logic [63:0] seed_val, input logic [7:0] strb);
      int          cnt;
      logic [9:0]  idx;
      logic [63:0] data;
      logic [7:0]  bstrb;
      idx = ref_index(addr);
      for (int i = 0; i <= len; i++) begin
         data = seed_val + i;
         bstrb = beat_strb(strb, i);
         w.data = data;
         w.strb = bstrb;
         w.last = (i == len);
         wvalid = 1'b1;
         cnt = 0;
         while (!wready && cnt < WAIT_MAX) begin
            @(negedge clk);
            cnt++;
         end
         if (!wready) begin
            $display("timeout: wready never rose for beat %0d", i);
            timed_out = 1'b1;
            errors++;
            break;
         end
         for (int k = 0; k < 8; k++) begin
            if (bstrb[k]) begin
               ref_mem[idx][k*8 +: 8] = data[k*8 +: 8];
            end
         end
         idx = idx + 1'b1;
         @(negedge clk);
      end
      wvalid = 1'b0;
   endtask

   task automatic collect_b(input string name, input logic [3:0] exp_id);
      int cnt;
      cnt = 0;
      bready = 1'b1;
      while (!bvalid && cnt < WAIT_MAX) begin
         @(negedge clk);
         cnt++;
      end
      if (!bvalid) begin
         $display("timeout: %s got no write response", name);
         timed_out = 1'b1;
         errors++;
      end else if (b.id !== exp_id) begin
         $display("MISMATCH %s bid expected %0d actual %0d", name, exp_id, b.id);
         errors++;
      end
      @(negedge clk);
      bready = 1'b0;
   endtask

   task automatic collect_r(input string name, input test_t row);
      int                    cnt;
      int                    beat;
      int                    rnd;
      logic [9:0]            idx;
      logic                  held;
      gmem_axi_pkg::r_beat_t held_r;
      idx = ref_index(row.addr);
      beat = 0;
      cnt = 0;
      held = 1'b0;
      while (beat <= row.len && cnt < WAIT_MAX) begin
         if (held && (!rvalid || r !== held_r)) begin
            $display("%s: R beat %0d changed while rready was low", name, beat);
            errors++;
         end
         if (row.throttle) begin
            rnd = $random(seed);
            rready = rnd[0];
         end else begin
            rready = 1'b1;
         end
         if (rvalid && rready) begin
            if (r.data !== ref_mem[idx]) begin
               $display("MISMATCH %s beat %0d data expected %h actual %h",
                        name, beat, ref_mem[idx], r.data);
               errors++;
            end
            if (r.id !== row.id) begin
               $display("MISMATCH %s rid expected %0d actual %0d", name, row.id, r.id);
               errors++;
            end
            if (r.last !== (beat == row.len)) begin
               $display("MISMATCH %s beat %0d rlast expected %0d actual %0d",
                        name, beat, beat == row.len, r.last);
               errors++;
            end
            idx = idx + 1'b1;
            beat++;
         end
         held = rvalid && !rready;
         held_r = r;
         @(negedge clk);
         cnt++;
      end
      if (beat <= row.len) begin
         $display("timeout: %s received %0d of %0d read beats", name, beat, row.len + 1);
         timed_out = 1'b1;
         errors++;
      end
      // no beat may follow rlast
      rready = 1'b1;
      repeat (3) begin
         if (rvalid) begin
            $display("%s: extra read beat after the last one", name);
            errors++;
         end
         @(negedge clk);
      end
      rready = 1'b0;
   endtask

   // one burst sits in the write FSM and eight fill the queue
   task automatic fill_queue(input string name, input test_t row);
      gmem_axi_pkg::addr_req_t req;
      for (int k = 0; k < QUEUE_BURSTS; k++) begin
         req.addr = row.addr + k * 16;
         req.len = row.len;
         req.id = row.id + k;
         do_aw(req);
      end
      aw.addr = row.addr + QUEUE_BURSTS * 16;
      aw.id = row.id + QUEUE_BURSTS;
      awvalid = 1'b1;
      repeat (4) begin
         if (awready) begin
            $display("%s: awready high while the queue is full", name);
            errors++;
         end
         @(negedge clk);
      end
      awvalid = 1'b0;
      for (int k = 0; k < QUEUE_BURSTS && !timed_out; k++) begin
         send_burst(row.addr + k * 16, row.len, row.seed + k * 256, row.strb);
         collect_b(name, row.id + k);
      end
   endtask

   task automatic report_test(input string name, input int err_before);
      if (errors == err_before) begin
         passed++;
         $display("test %s: ok", name);
      end else begin
         failed++;
         $display("test %s: failed with %0d errors", name, errors - err_before);
      end
   endtask

   initial begin
      gmem_axi_pkg::addr_req_t req;
      test_t                   row;
      int                      cnt;
      int                      err_before;
      nrst = 1'b1;
      ar = '0;
      arvalid = 1'b0;
      aw = '0;
      awvalid = 1'b0;
      w = '0;
      wvalid = 1'b0;
      rready = 1'b0;
      bready = 1'b0;
      errors = 0;
      passed = 0;
      failed = 0;
      timed_out = 1'b0;
      for (int i = 0; i < 1024; i++) begin
         ref_mem[i] = '0;
      end
      load_table();
      repeat (2) @(negedge clk);
      nrst = 1'b0;

      err_before = errors;
      if (arready || awready || wready || rvalid || bvalid) begin
         $display("reset: a ready or valid output is high after reset");
         errors++;
      end
      cnt = 0;
      while (!awready && cnt < WAIT_MAX) begin
         @(negedge clk);
         cnt++;
      end
      if (!awready) begin
         $display("timeout: awready never rose after reset");
         timed_out = 1'b1;
         errors++;
      end
      report_test("reset", err_before);

      for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
         row = tests[t];
         err_before = errors;
         req.addr = row.addr;
         req.len = row.len;
         req.id = row.id;
         case (row.kind)
            op_write: begin
               do_aw(req);
               send_burst(row.addr, row.len, row.seed, row.strb);
               collect_b(names[t], row.id);
            end
            op_read: begin
               do_ar(req);
               collect_r(names[t], row);
            end
            default: fill_queue(names[t], row);
         endcase
         report_test(names[t], err_before);
      end

      $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== global_mem.sv ====
`default_nettype none

module global_mem (
   input  logic                    clk,
   input  logic                    nrst,
   input  gmem_axi_pkg::addr_req_t ar,
   input  logic                    arvalid,
   output logic                    arready,
   input  gmem_axi_pkg::addr_req_t aw,
   input  logic                    awvalid,
   output logic                    awready,
   input  gmem_axi_pkg::w_beat_t   w,
   input  logic                    wvalid,
   output logic                    wready,
   output gmem_axi_pkg::r_beat_t   r,
   output logic                    rvalid,
   input  logic                    rready,
   output gmem_axi_pkg::b_resp_t   b,
   output logic                    bvalid,
   input  logic                    bready
);

   gmem_axi_pkg::addr_req_t awq_head;
   logic                    awq_not_empty;
   logic                    awq_pop;

   logic                                 wr_en;
   logic [gmem_cfg_pkg::MEM_WORDS_W-1:0] wr_index;
   logic [gmem_cfg_pkg::GMEM_DATA_W-1:0] wr_data;
   logic [gmem_cfg_pkg::GMEM_STRB_W-1:0] wr_strb;

   logic                                 rd_en;
   logic [gmem_cfg_pkg::MEM_WORDS_W-1:0] rd_index;
   logic [gmem_cfg_pkg::GMEM_DATA_W-1:0] rd_data;

   gmem_aw_queue u_aw_queue (
      .clk       (clk),
      .nrst      (nrst),
      .aw        (aw),
      .awvalid   (awvalid),
      .awready   (awready),
      .head      (awq_head),
      .not_empty (awq_not_empty),
      .pop       (awq_pop)
   );

   gmem_write_ctrl u_write_ctrl (
      .clk       (clk),
      .nrst      (nrst),
      .head      (awq_head),
      .not_empty (awq_not_empty),
      .pop       (awq_pop),
      .w         (w),
      .wvalid    (wvalid),
      .wready    (wready),
      .b         (b),
      .bvalid    (bvalid),
      .bready    (bready),
      .wr_en     (wr_en),
      .wr_index  (wr_index),
      .wr_data   (wr_data),
      .wr_strb   (wr_strb)
   );

   gmem_read_ctrl u_read_ctrl (
      .clk      (clk),
      .nrst     (nrst),
      .ar       (ar),
      .arvalid  (arvalid),
      .arready  (arready),
      .r        (r),
      .rvalid   (rvalid),
      .rready   (rready),
      .rd_en    (rd_en),
      .rd_index (rd_index),
      .rd_data  (rd_data)
   );

   gmem_array u_array (
      .clk      (clk),
      .wr_en    (wr_en),
      .wr_index (wr_index),
      .wr_data  (wr_data),
      .wr_strb  (wr_strb),
      .rd_en    (rd_en),
      .rd_index (rd_index),
      .rd_data  (rd_data)
   );

endmodule

`default_nettype wire

// ==== gmem_array.sv ====
`default_nettype none

module gmem_array (
   input  logic                                 clk,
   input  logic                                 wr_en,
   input  logic [gmem_cfg_pkg::MEM_WORDS_W-1:0] wr_index,
   input  logic [gmem_cfg_pkg::GMEM_DATA_W-1:0] wr_data,
   input  logic [gmem_cfg_pkg::GMEM_STRB_W-1:0] wr_strb,
   input  logic                                 rd_en,
   input  logic [gmem_cfg_pkg::MEM_WORDS_W-1:0] rd_index,
   output logic [gmem_cfg_pkg::GMEM_DATA_W-1:0] rd_data
);

   logic [gmem_cfg_pkg::GMEM_DATA_W-1:0] mem [gmem_cfg_pkg::MEM_WORDS] = '{default: '0};

   // per-byte write enable
   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int i = 0; i < gmem_cfg_pkg::GMEM_STRB_W; i++) begin
            if (wr_strb[i]) begin
               mem[wr_index][i*8 +: 8] <= wr_data[i*8 +: 8];
            end
         end
      end
   end

   // same-word collision returns old data
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_data <= mem[rd_index];
      end
   end

endmodule

`default_nettype wire

// ==== gmem_read_ctrl.sv ====
`default_nettype none

module gmem_read_ctrl (
   input  logic                                 clk,
   input  logic                                 nrst,
   input  gmem_axi_pkg::addr_req_t              ar,
   input  logic                                 arvalid,
   output logic                                 arready,
   output gmem_axi_pkg::r_beat_t                r,
   output logic                                 rvalid,
   input  logic                                 rready,
   output logic                                 rd_en,
   output logic [gmem_cfg_pkg::MEM_WORDS_W-1:0] rd_index,
   input  logic [gmem_cfg_pkg::GMEM_DATA_W-1:0] rd_data
);

   gmem_cfg_pkg::read_state_e state;

   logic [gmem_cfg_pkg::MEM_WORDS_W-1:0] rd_idx;
   logic [gmem_cfg_pkg::LEN_W-1:0]       burst_len;
   logic [gmem_cfg_pkg::LEN_W-1:0]       issue_cnt;
   logic [gmem_cfg_pkg::ID_W-1:0]        burst_id;

   logic issue_done;
   logic issued_q;
   logic issued_last;
   logic slot_free;
   logic ar_fire;
   logic r_fire;

   assign slot_free = !rvalid || rready;
   assign ar_fire   = arvalid && arready;
   assign r_fire    = rvalid && rready;
   assign rd_en     = (state == gmem_cfg_pkg::rd_send) && !issue_done && slot_free;
   assign rd_index  = rd_idx;

   always_ff @(posedge clk) begin
      if (nrst) begin
         state      <= gmem_cfg_pkg::rd_idle;
         arready    <= 1'b0;
         rvalid     <= 1'b0;
         issue_done <= 1'b0;
         issued_q   <= 1'b0;
      end else begin
         // one-cycle pulse per request
         arready <= (state == gmem_cfg_pkg::rd_idle) && arvalid && !arready;
         case (state)
            gmem_cfg_pkg::rd_idle: begin
               if (ar_fire) begin
                  state      <= gmem_cfg_pkg::rd_send;
                  issue_done <= 1'b0;
               end
            end
            gmem_cfg_pkg::rd_send: begin
               if (rd_en && issue_cnt == burst_len) begin
                  issue_done <= 1'b1;
               end
               if (r_fire && r.last) begin
                  state <= gmem_cfg_pkg::rd_idle;
               end
            end
            default: state <= gmem_cfg_pkg::rd_idle;
         endcase
         // array output holds a pending word until the slot frees
         issued_q <= rd_en || (issued_q && !slot_free);
         if (issued_q && slot_free) begin
            rvalid <= 1'b1;
         end else if (rready) begin
            rvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ar_fire) begin
         rd_idx    <= gmem_cfg_pkg::word_index(ar.addr);
         burst_len <= ar.len;
         burst_id  <= ar.id;
         issue_cnt <= '0;
      end else if (rd_en) begin
         rd_idx    <= rd_idx + 1'b1;
         issue_cnt <= issue_cnt + 1'b1;
      end
      if (rd_en) begin
         issued_last <= issue_cnt == burst_len;
      end
      if (issued_q && slot_free) begin
         r.data <= rd_data;
         r.last <= issued_last;
         r.id   <= burst_id;
      end
   end

endmodule

`default_nettype wire

// ==== gmem_write_ctrl.sv ====
`default_nettype none

module gmem_write_ctrl (
   input  logic                                   clk,
   input  logic                                   nrst,
   input  gmem_axi_pkg::addr_req_t                head,
   input  logic                                   not_empty,
   output logic                                   pop,
   input  gmem_axi_pkg::w_beat_t                  w,
   input  logic                                   wvalid,
   output logic                                   wready,
   output gmem_axi_pkg::b_resp_t                  b,
   output logic                                   bvalid,
   input  logic                                   bready,
   output logic                                   wr_en,
   output logic [gmem_cfg_pkg::MEM_WORDS_W-1:0]   wr_index,
   output logic [gmem_cfg_pkg::GMEM_DATA_W-1:0]   wr_data,
   output logic [gmem_cfg_pkg::GMEM_STRB_W-1:0]   wr_strb
);

   gmem_cfg_pkg::write_state_e state;

   logic [gmem_cfg_pkg::MEM_WORDS_W-1:0] cur_index;
   logic [gmem_cfg_pkg::ID_W-1:0]        cur_id;

   // completed burst ids waiting for B
   logic [gmem_cfg_pkg::ID_W-1:0] bid_buf [2];
   logic                          bid_wr_ptr;
   logic                          bid_rd_ptr;
   logic [1:0]                    bid_count;

   logic w_fire;
   logic b_fire;
   logic burst_done;
   logic take_head;

   assign wready     = (state == gmem_cfg_pkg::wr_data) && (bid_count != 2'd2);
   assign w_fire     = wvalid && wready;
   assign burst_done = w_fire && w.last;
   assign take_head  = not_empty && ((state == gmem_cfg_pkg::wr_get_address) || burst_done);
   assign pop        = take_head;

   assign bvalid = bid_count != 2'd0;
   assign b_fire = bvalid && bready;
   assign b.id   = bid_buf[bid_rd_ptr];

   always_ff @(posedge clk) begin
      if (nrst) begin
         state <= gmem_cfg_pkg::wr_get_address;
      end else if (take_head) begin
         state <= gmem_cfg_pkg::wr_data;
      end else if (burst_done) begin
         state <= gmem_cfg_pkg::wr_get_address;
      end
   end

   // next burst overrides the increment on its last beat
   always_ff @(posedge clk) begin
      if (take_head) begin
         cur_index <= gmem_cfg_pkg::word_index(head.addr);
         cur_id    <= head.id;
      end else if (w_fire) begin
         cur_index <= cur_index + 1'b1;
      end
   end

   // array write one edge after the handshake
   always_ff @(posedge clk) begin
      if (nrst) begin
         wr_en <= 1'b0;
      end else begin
         wr_en <= w_fire;
      end
   end

   always_ff @(posedge clk) begin
      if (w_fire) begin
         wr_index <= cur_index;
         wr_data  <= w.data;
         wr_strb  <= w.strb;
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         bid_wr_ptr <= 1'b0;
         bid_rd_ptr <= 1'b0;
         bid_count  <= 2'd0;
      end else begin
         if (burst_done) begin
            bid_wr_ptr <= !bid_wr_ptr;
         end
         if (b_fire) begin
            bid_rd_ptr <= !bid_rd_ptr;
         end
         case ({burst_done, b_fire})
            2'b10: bid_count <= bid_count + 1'b1;
            2'b01: bid_count <= bid_count - 1'b1;
            default: bid_count <= bid_count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (burst_done) begin
         bid_buf[bid_wr_ptr] <= cur_id;
      end
   end

endmodule

`default_nettype wire

// ==== gmem_aw_queue.sv ====
`default_nettype none

module gmem_aw_queue (
   input  logic                    clk,
   input  logic                    nrst,
   input  gmem_axi_pkg::addr_req_t aw,
   input  logic                    awvalid,
   output logic                    awready,
   output gmem_axi_pkg::addr_req_t head,
   output logic                    not_empty,
   input  logic                    pop
);

   gmem_axi_pkg::addr_req_t entries [gmem_cfg_pkg::AWQ_DEPTH];

   logic [gmem_cfg_pkg::AWQ_DEPTH_W-1:0] wr_ptr;
   logic [gmem_cfg_pkg::AWQ_DEPTH_W-1:0] rd_ptr;
   logic [gmem_cfg_pkg::AWQ_DEPTH_W:0]   count;
   logic [gmem_cfg_pkg::AWQ_DEPTH_W:0]   count_next;
   logic                                 push;

   assign push = awvalid && awready;
   assign head = entries[rd_ptr];

   always_comb begin
      count_next = count;
      case ({push, pop})
         2'b10: count_next = count + 1'b1;
         2'b01: count_next = count - 1'b1;
         default: count_next = count;
      endcase
   end

   // flags registered from the next fill level
   always_ff @(posedge clk) begin
      if (nrst) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         awready   <= 1'b0;
         not_empty <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count     <= count_next;
         awready   <= count_next != gmem_cfg_pkg::AWQ_DEPTH;
         not_empty <= count_next != '0;
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         entries[wr_ptr] <= aw;
      end
   end

endmodule

`default_nettype wire

// ==== gmem_axi_pkg.sv ====
`default_nettype none

package gmem_axi_pkg;

   // shared by AR and AW
   typedef struct packed {
      logic [gmem_cfg_pkg::GMEM_ADDR_W-1:0] addr;
      logic [gmem_cfg_pkg::LEN_W-1:0]       len;
      logic [gmem_cfg_pkg::ID_W-1:0]        id;
   } addr_req_t;

   typedef struct packed {
      logic [gmem_cfg_pkg::GMEM_DATA_W-1:0] data;
      logic [gmem_cfg_pkg::GMEM_STRB_W-1:0] strb;
      logic                                 last;
   } w_beat_t;

   typedef struct packed {
      logic [gmem_cfg_pkg::GMEM_DATA_W-1:0] data;
      logic                                 last;
      logic [gmem_cfg_pkg::ID_W-1:0]        id;
   } r_beat_t;

   // B carries only the id
   typedef struct packed {
      logic [gmem_cfg_pkg::ID_W-1:0] id;
   } b_resp_t;

endpackage

`default_nettype wire

// ==== gmem_cfg_pkg.sv ====
`default_nettype none

package gmem_cfg_pkg;

   // word and bus geometry
   localparam int GMEM_DATA_W = 64;
   localparam int GMEM_STRB_W = GMEM_DATA_W / 8;
   localparam int GMEM_ADDR_W = 32;
   localparam int ID_W = 4;
   localparam int LEN_W = 8;

   // 1024 words of storage
   localparam int MEM_WORDS_W = 10;
   localparam int MEM_WORDS = 1 << MEM_WORDS_W;

   localparam logic [GMEM_ADDR_W-1:0] ADDR_OFFSET = 'h1000_0000;
   localparam int WORD_SHIFT = 3;

   // write address queue of 8 entries
   localparam int AWQ_DEPTH_W = 3;
   localparam logic [AWQ_DEPTH_W:0] AWQ_DEPTH = 1 << AWQ_DEPTH_W;

   typedef enum logic {
      wr_get_address,
      wr_data
   } write_state_e;

   typedef enum logic {
      rd_idle,
      rd_send
   } read_state_e;

   // byte address to word index with wrap modulo the array depth
   function automatic logic [MEM_WORDS_W-1:0] word_index(input logic [GMEM_ADDR_W-1:0] addr);
      logic [GMEM_ADDR_W-1:0] rel;
      rel = addr - ADDR_OFFSET;
      return rel[WORD_SHIFT +: MEM_WORDS_W];
   endfunction

endpackage

`default_nettype wire
